// ==== files.f ====
xbar_pkg.sv
icache.sv
clint.sv
mem_xbar.sv
mem_subsys.sv
tb_mem_slave.sv
tb_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - xbar_pkg.sv
  - icache.sv
  - clint.sv
  - mem_xbar.sv
  - mem_subsys.sv
  - target: test
    files:
      - tb_mem_slave.sv
      - tb_mem_subsys.sv

// ==== tb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

	logic clock, reset;

	xbar_pkg::ar_req_t ifu_ar, lsu_ar, ext_ar;
	xbar_pkg::r_rsp_t  ifu_r, lsu_r, ext_r;
	xbar_pkg::aw_req_t lsu_aw, ext_aw;
	xbar_pkg::w_beat_t lsu_w, ext_w;
	xbar_pkg::resp_t   lsu_bresp, ext_bresp;
	logic ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
	logic lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
	logic lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_bvalid, lsu_bready;
	logic ext_arvalid, ext_arready, ext_rvalid, ext_rready;
	logic ext_awvalid, ext_awready, ext_wvalid, ext_wready, ext_bvalid, ext_bready;
	logic mem_stalled;

	// cache tag model
	logic                               tag_ok [xbar_pkg::ICACHE_LINES];
	logic [31:xbar_pkg::ICACHE_IDX_W+2] tag_q  [xbar_pkg::ICACHE_LINES];
	xbar_pkg::word_t                    last_mtime;

	mem_subsys dut (.*);

	tb_mem_slave mem (
		.clock   (clock),
		.reset   (reset),
		.ar      (ext_ar),
		.arvalid (ext_arvalid),
		.arready (ext_arready),
		.r       (ext_r),
		.rvalid  (ext_rvalid),
		.rready  (ext_rready),
		.aw      (ext_aw),
		.awvalid (ext_awvalid),
		.awready (ext_awready),
		.w       (ext_w),
		.wvalid  (ext_wvalid),
		.wready  (ext_wready),
		.bresp   (ext_bresp),
		.bvalid  (ext_bvalid),
		.bready  (ext_bready),
		.stalled (mem_stalled)
	);

	always #5 clock = ~clock;

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [71:0] got,
			input logic [71:0] exp);
		assert (got === exp) else
			stop_run($sformatf("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	always @(posedge clock) begin
		assert (!mem_stalled) else
			stop_run("external memory model waited too long for a ready");
	end

	// small pool with several tags per index
	function automatic xbar_pkg::addr_t pool_addr();
		return 32'h8000_0000 + ($urandom_range(2) << 6) + ($urandom_range(5) << 2);
	endfunction

	function automatic xbar_pkg::ar_req_t ext_req();
		xbar_pkg::addr_t a;
		a = $urandom;
		if ((a >= xbar_pkg::CLINT_BASE) && (a <= xbar_pkg::CLINT_LAST))
			a = xbar_pkg::CLINT_LAST + 1; // just past the window
		return '{addr: a, size: xbar_pkg::size_t'($urandom_range(3))};
	endfunction

	function automatic xbar_pkg::ar_req_t clint_req();
		return '{addr: xbar_pkg::CLINT_BASE + $urandom_range(32'hffff), size: xbar_pkg::SIZE_WORD};
	endfunction

	// ****************************************
	// reads from one or both units
	// ****************************************

	task automatic run_reads(input logic want_ifu, input xbar_pkg::addr_t fa,
			input logic want_lsu, input xbar_pkg::ar_req_t la);
		logic [xbar_pkg::ICACHE_IDX_W-1:0] idx;
		logic hit, in_clint, ifu_hs, lsu_hs, ifu_done, lsu_done;
		xbar_pkg::r_rsp_t ifu_got, lsu_got;
		int n, k;
		idx         = fa[xbar_pkg::ICACHE_IDX_W+1:2];
		hit         = tag_ok[idx] && (tag_q[idx] == fa[31:xbar_pkg::ICACHE_IDX_W+2]);
		in_clint    = (la.addr >= xbar_pkg::CLINT_BASE) && (la.addr <= xbar_pkg::CLINT_LAST);
		k           = mem.ar_log.size();
		ifu_done    = !want_ifu;
		lsu_done    = !want_lsu;
		ifu_ar      = '{addr: fa, size: xbar_pkg::SIZE_WORD};
		ifu_arvalid = want_ifu;
		lsu_ar      = la;
		lsu_arvalid = want_lsu;
		for (n = 0; !(ifu_done && lsu_done); n++) begin
			assert (n < 200) else
				stop_run("read response did not arrive in time");
			@(posedge clock);
			ifu_hs = ifu_arvalid && ifu_arready;
			lsu_hs = lsu_arvalid && lsu_arready;
			assert (!lsu_hs || ifu_done) else
				stop_run("LSU read accepted before the IFU reply");
			if (ifu_rvalid && ifu_rready) begin
				ifu_got  = ifu_r;
				ifu_done = 1'b1;
			end
			if (lsu_rvalid && lsu_rready) begin
				lsu_got  = lsu_r;
				lsu_done = 1'b1;
			end
			#1;
			if (ifu_hs)
				ifu_arvalid = 1'b0;
			if (lsu_hs)
				lsu_arvalid = 1'b0;
			ifu_rready = ($urandom_range(1) != 0);
			lsu_rready = ($urandom_range(1) != 0);
		end
		ifu_rready = 1'b0;
		lsu_rready = 1'b0;

		assert (mem.ar_log.size() == k + (want_ifu && !hit) + (want_lsu && !in_clint)) else
			stop_run("wrong number of external read requests");
		if (want_ifu) begin
			check_value("ifu_r", ifu_got, {32'b0, fa ^ 32'h5a5a_0000, xbar_pkg::resp_okay});
			if (!hit) begin // miss goes out first
				check_value("ext_ar", mem.ar_log[k], {fa, xbar_pkg::SIZE_WORD});
				k++;
			end
			tag_ok[idx] = 1'b1;
			tag_q[idx]  = fa[31:xbar_pkg::ICACHE_IDX_W+2];
		end
		if (want_lsu && in_clint) begin
			check_value("lsu_r.data[63:32]", lsu_got.data[63:32], 32'b0);
			check_value("lsu_r.resp", lsu_got.resp, xbar_pkg::resp_okay);
			assert (lsu_got.data[31:0] > last_mtime) else
				stop_run($sformatf("Fail at time %0t: lsu_r.data[31:0] is %h, expected above %h",
					$time, lsu_got.data[31:0], last_mtime));
			last_mtime = lsu_got.data[31:0];
		end else if (want_lsu) begin
			check_value("ext_ar", mem.ar_log[k], la);
			check_value("lsu_r", lsu_got, {~la.addr, la.addr ^ 32'h5a5a_0000, xbar_pkg::resp_okay});
		end
	endtask

	task automatic lsu_write();
		xbar_pkg::aw_req_t a;
		xbar_pkg::w_beat_t d;
		xbar_pkg::resp_t got;
		logic aw_hs, w_hs, done;
		int n, k;
		a           = '{addr: $urandom, size: xbar_pkg::size_t'($urandom_range(3))};
		d           = '{data: {$urandom, $urandom}, strb: xbar_pkg::strb_t'($urandom)};
		k           = mem.aw_log.size();
		done        = 1'b0;
		lsu_aw      = a;
		lsu_w       = d;
		lsu_awvalid = 1'b1;
		lsu_wvalid  = 1'b1;
		for (n = 0; !done; n++) begin
			assert (n < 200) else
				stop_run("write response did not arrive in time");
			@(posedge clock);
			aw_hs = lsu_awvalid && lsu_awready;
			w_hs  = lsu_wvalid && lsu_wready;
			if (lsu_bvalid && lsu_bready) begin
				got  = lsu_bresp;
				done = 1'b1;
			end
			#1;
			if (aw_hs)
				lsu_awvalid = 1'b0;
			if (w_hs)
				lsu_wvalid = 1'b0;
			lsu_bready = ($urandom_range(1) != 0);
		end
		lsu_bready = 1'b0;
		assert ((mem.aw_log.size() == k + 1) && (mem.w_log.size() == k + 1)) else
			stop_run("write did not reach the external port exactly once");
		check_value("ext_aw", mem.aw_log[k], a);
		check_value("ext_w", mem.w_log[k], d);
		check_value("lsu_bresp", got, mem.b_log[k]);
	endtask

	initial begin
		int i, kind;
		void'($urandom(32'h822f_dbf7));
		clock       = 1'b0;
		reset       = 1'b1;
		ifu_ar      = '0;
		ifu_arvalid = 1'b0;
		ifu_rready  = 1'b0;
		lsu_ar      = '0;
		lsu_arvalid = 1'b0;
		lsu_rready  = 1'b0;
		lsu_aw      = '0;
		lsu_awvalid = 1'b0;
		lsu_w       = '0;
		lsu_wvalid  = 1'b0;
		lsu_bready  = 1'b0;
		last_mtime  = '0;
		for (i = 0; i < xbar_pkg::ICACHE_LINES; i++)
			tag_ok[i] = 1'b0;

		repeat (16) @(posedge clock);
		#1;
		reset = 1'b0;
		check_value("ifu_rvalid", ifu_rvalid, 1'b0);
		check_value("lsu_rvalid", lsu_rvalid, 1'b0);
		check_value("ext_arvalid", ext_arvalid, 1'b0);

		run_reads(1'b1, pool_addr(), 1'b1, ext_req()); // tie on an empty cache
		for (i = 0; i < 150; i++) begin
			kind = $urandom_range(9);
			if (kind < 4)
				run_reads(1'b1, pool_addr(), 1'b0, ext_req());
			else if (kind < 6)
				run_reads(1'b0, '0, 1'b1, ext_req());
			else if (kind == 6)
				run_reads(1'b0, '0, 1'b1, clint_req());
			else if (kind < 9)
				lsu_write();
			else
				run_reads(1'b1, pool_addr(), 1'b1,
					($urandom_range(1) != 0) ? ext_req() : clint_req());
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb_mem_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_slave (
	input  wire                    clock,
	input  wire                    reset,

	input  wire xbar_pkg::ar_req_t ar,
	input  wire                    arvalid,
	output logic                   arready,
	output xbar_pkg::r_rsp_t       r,
	output logic                   rvalid,
	input  wire                    rready,

	input  wire xbar_pkg::aw_req_t aw,
	input  wire                    awvalid,
	output logic                   awready,
	input  wire xbar_pkg::w_beat_t w,
	input  wire                    wvalid,
	output logic                   wready,
	output xbar_pkg::resp_t        bresp,
	output logic                   bvalid,
	input  wire                    bready,

	output logic                   stalled
);

	xbar_pkg::ar_req_t ar_log [$]; // every accepted read address
	xbar_pkg::aw_req_t aw_log [$];
	xbar_pkg::w_beat_t w_log [$];
	xbar_pkg::resp_t   b_log [$]; // responses sent back

	logic rd_stalled, wr_stalled;

	assign stalled = rd_stalled | wr_stalled;

	// from 1 ns after an edge to 1 ns after the n-th edge
	task automatic cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	// ****************************************
	// read side, sampled 1 ns after the edge
	// ****************************************

	initial begin
		xbar_pkg::ar_req_t req;
		logic taken;
		int n;
		arready    = 1'b0;
		rvalid     = 1'b0;
		r          = '0;
		rd_stalled = 1'b0;
		cycles(1);
		forever begin
			if (!reset && arvalid) begin
				req = ar;
				cycles($urandom_range(3));
				arready = 1'b1;
				cycles(1); // address taken on that edge
				ar_log.push_back(req);
				arready = 1'b0;
				cycles($urandom_range(3));
				r      = '{data: {~req.addr, req.addr ^ 32'h5a5a_0000}, resp: xbar_pkg::resp_okay};
				rvalid = 1'b1;
				taken  = 1'b0;
				for (n = 0; !taken && !rd_stalled; n++) begin
					taken = rready;
					cycles(1);
					if (n > 100)
						rd_stalled = 1'b1;
				end
				rvalid = 1'b0;
			end else begin
				cycles(1);
			end
		end
	end

	// ****************************************
	// write side, sampled at the edge
	// ****************************************

	initial begin
		xbar_pkg::aw_req_t a;
		xbar_pkg::w_beat_t d;
		logic taken;
		int n;
		awready    = 1'b0;
		wready     = 1'b0;
		bvalid     = 1'b0;
		bresp      = xbar_pkg::resp_okay;
		wr_stalled = 1'b0;
		forever begin
			@(posedge clock);
			if (!reset && awvalid && wvalid) begin
				a = aw;
				d = w;
				repeat ($urandom_range(3)) @(posedge clock);
				#1;
				awready = 1'b1;
				wready  = 1'b1;
				cycles(1);
				aw_log.push_back(a);
				w_log.push_back(d);
				awready = 1'b0;
				wready  = 1'b0;
				cycles($urandom_range(3));
				bresp  = ($urandom_range(1) != 0) ? xbar_pkg::resp_okay : 2'b10; // okay or slverr
				b_log.push_back(bresp);
				bvalid = 1'b1;
				taken  = 1'b0;
				for (n = 0; !taken && !wr_stalled; n++) begin
					@(posedge clock);
					taken = bready;
					if (n > 100)
						wr_stalled = 1'b1;
				end
				#1;
				bvalid = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys (
	input  wire                    clock,
	input  wire                    reset,

	input  wire xbar_pkg::ar_req_t ifu_ar,
	input  wire                    ifu_arvalid,
	output logic                   ifu_arready,
	output xbar_pkg::r_rsp_t       ifu_r,
	output logic                   ifu_rvalid,
	input  wire                    ifu_rready,

	input  wire xbar_pkg::ar_req_t lsu_ar,
	input  wire                    lsu_arvalid,
	output logic                   lsu_arready,
	output xbar_pkg::r_rsp_t       lsu_r,
	output logic                   lsu_rvalid,
	input  wire                    lsu_rready,
	input  wire xbar_pkg::aw_req_t lsu_aw,
	input  wire                    lsu_awvalid,
	output logic                   lsu_awready,
	input  wire xbar_pkg::w_beat_t lsu_w,
	input  wire                    lsu_wvalid,
	output logic                   lsu_wready,
	output xbar_pkg::resp_t        lsu_bresp,
	output logic                   lsu_bvalid,
	input  wire                    lsu_bready,

	output xbar_pkg::ar_req_t      ext_ar,
	output logic                   ext_arvalid,
	input  wire                    ext_arready,
	input  wire xbar_pkg::r_rsp_t  ext_r,
	input  wire                    ext_rvalid,
	output logic                   ext_rready,
	output xbar_pkg::aw_req_t      ext_aw,
	output logic                   ext_awvalid,
	input  wire                    ext_awready,
	output xbar_pkg::w_beat_t      ext_w,
	output logic                   ext_wvalid,
	input  wire                    ext_wready,
	input  wire xbar_pkg::resp_t   ext_bresp,
	input  wire                    ext_bvalid,
	output logic                   ext_bready
);

	xbar_pkg::addr_t ic_araddr, ic_awaddr, cl_araddr;
	xbar_pkg::word_t ic_rdata, ic_wdata, cl_rdata;
	xbar_pkg::resp_t ic_rresp;
	logic ic_arvalid, ic_arready, ic_rvalid, ic_rready;
	logic ic_awvalid, ic_awready, ic_wvalid, ic_wready, ic_bvalid, ic_bready;
	logic cl_arvalid, cl_arready, cl_rvalid, cl_rready;

	mem_xbar u_xbar (
		.*,
		.ic_r ({32'b0, ic_rdata, ic_rresp}) // cache word in the low half
	);

	icache u_icache (
		.clock   (clock),
		.reset   (reset),
		.araddr  (ic_araddr),
		.arvalid (ic_arvalid),
		.arready (ic_arready),
		.rdata   (ic_rdata),
		.rresp   (ic_rresp),
		.rvalid  (ic_rvalid),
		.rready  (ic_rready),
		.awaddr  (ic_awaddr),
		.awvalid (ic_awvalid),
		.awready (ic_awready),
		.wdata   (ic_wdata),
		.wvalid  (ic_wvalid),
		.wready  (ic_wready),
		.bvalid  (ic_bvalid),
		.bready  (ic_bready)
	);

	clint u_clint (
		.clock   (clock),
		.reset   (reset),
		.araddr  (cl_araddr),
		.arvalid (cl_arvalid),
		.arready (cl_arready),
		.rdata   (cl_rdata),
		.rvalid  (cl_rvalid),
		.rready  (cl_rready)
	);

endmodule

`default_nettype wire

// ==== mem_xbar.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_xbar (
	input  wire                      clock,
	input  wire                      reset,

	input  wire xbar_pkg::ar_req_t   ifu_ar,
	input  wire                      ifu_arvalid,
	output logic                     ifu_arready,
	output xbar_pkg::r_rsp_t         ifu_r,
	output logic                     ifu_rvalid,
	input  wire                      ifu_rready,

	input  wire xbar_pkg::ar_req_t   lsu_ar,
	input  wire                      lsu_arvalid,
	output logic                     lsu_arready,
	output xbar_pkg::r_rsp_t         lsu_r,
	output logic                     lsu_rvalid,
	input  wire                      lsu_rready,
	input  wire xbar_pkg::aw_req_t   lsu_aw,
	input  wire                      lsu_awvalid,
	output logic                     lsu_awready,
	input  wire xbar_pkg::w_beat_t   lsu_w,
	input  wire                      lsu_wvalid,
	output logic                     lsu_wready,
	output xbar_pkg::resp_t          lsu_bresp,
	output logic                     lsu_bvalid,
	input  wire                      lsu_bready,

	output xbar_pkg::ar_req_t        ext_ar,
	output logic                     ext_arvalid,
	input  wire                      ext_arready,
	input  wire xbar_pkg::r_rsp_t    ext_r,
	input  wire                      ext_rvalid,
	output logic                     ext_rready,
	output xbar_pkg::aw_req_t        ext_aw,
	output logic                     ext_awvalid,
	input  wire                      ext_awready,
	output xbar_pkg::w_beat_t        ext_w,
	output logic                     ext_wvalid,
	input  wire                      ext_wready,
	input  wire xbar_pkg::resp_t     ext_bresp,
	input  wire                      ext_bvalid,
	output logic                     ext_bready,

	output xbar_pkg::addr_t          ic_araddr,
	output logic                     ic_arvalid,
	input  wire                      ic_arready,
	input  wire xbar_pkg::r_rsp_t    ic_r,
	input  wire                      ic_rvalid,
	output logic                     ic_rready,
	output xbar_pkg::addr_t          ic_awaddr,
	output logic                     ic_awvalid,
	input  wire                      ic_awready,
	output xbar_pkg::word_t          ic_wdata,
	output logic                     ic_wvalid,
	input  wire                      ic_wready,
	input  wire                      ic_bvalid,
	output logic                     ic_bready,

	output xbar_pkg::addr_t          cl_araddr,
	output logic                     cl_arvalid,
	input  wire                      cl_arready,
	input  wire xbar_pkg::word_t     cl_rdata,
	input  wire                      cl_rvalid,
	output logic                     cl_rready
);

	typedef enum logic [2:0] {
		IDLE,
		IFU_LOOKUP,
		IFU_FETCH,
		IFU_FILL,
		IFU_REPLY,
		LSU_READ,
		LSU_REPLY
	} state_t;

	state_t state, state_n;

	xbar_pkg::addr_t  req_addr;
	xbar_pkg::size_t  req_size;
	logic             req_clint;
	xbar_pkg::r_rsp_t rsp_q; // answer for whichever unit is served

	logic ifu_ar_hs, lsu_ar_hs, lsu_in_clint;
	logic ic_ar_hs, ic_r_hs, ic_aw_hs, ic_w_hs, ic_b_hs;
	logic ext_ar_hs, ext_r_hs, cl_ar_hs, cl_r_hs;

	assign ifu_ar_hs = ifu_arvalid & ifu_arready;
	assign lsu_ar_hs = lsu_arvalid & lsu_arready;
	assign ic_ar_hs  = ic_arvalid & ic_arready;
	assign ic_r_hs   = ic_rvalid & ic_rready;
	assign ic_aw_hs  = ic_awvalid & ic_awready;
	assign ic_w_hs   = ic_wvalid & ic_wready;
	assign ic_b_hs   = ic_bvalid & ic_bready;
	assign ext_ar_hs = ext_arvalid & ext_arready;
	assign ext_r_hs  = ext_rvalid & ext_rready;
	assign cl_ar_hs  = cl_arvalid & cl_arready;
	assign cl_r_hs   = cl_rvalid & cl_rready;

	assign lsu_in_clint = (lsu_ar.addr >= xbar_pkg::CLINT_BASE) &&
		(lsu_ar.addr <= xbar_pkg::CLINT_LAST);

	// ****************************************
	// read state machine
	// ****************************************

	always_comb begin
		state_n = state;
		case (state)
			IDLE:
				if (ifu_ar_hs) state_n = IFU_LOOKUP;
				else if (lsu_ar_hs) state_n = LSU_READ;
			IFU_LOOKUP:
				if (ic_r_hs) state_n = ic_r.resp[1] ? IFU_FETCH : IFU_REPLY; // miss goes out
			IFU_FETCH:
				if (ext_r_hs) state_n = ext_r.resp[1] ? IFU_REPLY : IFU_FILL; // no fill on error
			IFU_FILL:
				if (ic_b_hs) state_n = IFU_REPLY;
			IFU_REPLY:
				if (ifu_rready) state_n = IDLE;
			LSU_READ:
				if (ext_r_hs | cl_r_hs) state_n = LSU_REPLY;
			LSU_REPLY:
				if (lsu_rready) state_n = IDLE;
			default:
				state_n = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= IDLE;
			ifu_arready <= 1'b0;
			lsu_arready <= 1'b0;
			ic_arvalid  <= 1'b0;
			ic_awvalid  <= 1'b0;
			ic_wvalid   <= 1'b0;
			ext_arvalid <= 1'b0;
			cl_arvalid  <= 1'b0;
		end else begin
			state <= state_n;
			// one-cycle grant pulses, ifu first
			ifu_arready <= (state == IDLE) & ifu_arvalid & ~ifu_arready & ~lsu_arready;
			lsu_arready <= (state == IDLE) & lsu_arvalid & ~ifu_arvalid &
				~ifu_arready & ~lsu_arready;

			if (ifu_ar_hs)
				ic_arvalid <= 1'b1;
			else if (ic_ar_hs)
				ic_arvalid <= 1'b0;

			if (((state == IFU_LOOKUP) & ic_r_hs & ic_r.resp[1]) | (lsu_ar_hs & ~lsu_in_clint))
				ext_arvalid <= 1'b1;
			else if (ext_ar_hs)
				ext_arvalid <= 1'b0;

			if (lsu_ar_hs & lsu_in_clint)
				cl_arvalid <= 1'b1;
			else if (cl_ar_hs)
				cl_arvalid <= 1'b0;

			if ((state == IFU_FETCH) & ext_r_hs & ~ext_r.resp[1]) begin
				ic_awvalid <= 1'b1;
				ic_wvalid  <= 1'b1;
			end else begin
				if (ic_aw_hs) ic_awvalid <= 1'b0;
				if (ic_w_hs) ic_wvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (ifu_ar_hs) begin
			req_addr  <= ifu_ar.addr;
			req_size  <= xbar_pkg::SIZE_WORD;
			req_clint <= 1'b0;
		end else if (lsu_ar_hs) begin
			req_addr  <= lsu_ar.addr;
			req_size  <= lsu_ar.size;
			req_clint <= lsu_in_clint; // decoded once here
		end

		if (ic_r_hs)
			rsp_q <= '{data: {32'b0, ic_r.data[31:0]}, resp: ic_r.resp};
		if (ext_r_hs) begin
			if (state == IFU_FETCH)
				rsp_q <= '{data: {32'b0, ext_r.data[31:0]}, resp: ext_r.resp};
			else
				rsp_q <= ext_r;
		end
		if (cl_r_hs)
			rsp_q <= '{data: {32'b0, cl_rdata}, resp: xbar_pkg::resp_okay};
	end

	assign ic_araddr  = req_addr;
	assign ic_awaddr  = req_addr;
	assign ic_wdata   = rsp_q.data[31:0]; // word just fetched
	assign ic_rready  = (state == IFU_LOOKUP);
	assign ic_bready  = (state == IFU_FILL);

	assign ext_ar     = '{addr: req_addr, size: req_size};
	assign ext_rready = (state == IFU_FETCH) | ((state == LSU_READ) & ~req_clint);
	assign cl_araddr  = req_addr;
	assign cl_rready  = (state == LSU_READ) & req_clint;

	assign ifu_r      = rsp_q;
	assign ifu_rvalid = (state == IFU_REPLY);
	assign lsu_r      = rsp_q;
	assign lsu_rvalid = (state == LSU_REPLY);

	// ****************************************
	// write pass-through
	// ****************************************

	assign ext_aw      = lsu_aw;
	assign ext_awvalid = lsu_awvalid;
	assign lsu_awready = ext_awready;
	assign ext_w       = lsu_w;
	assign ext_wvalid  = lsu_wvalid;
	assign lsu_wready  = ext_wready;
	assign lsu_bresp   = ext_bresp;
	assign lsu_bvalid  = ext_bvalid;
	assign ext_bready  = lsu_bready;

	a_one_target: assert property (@(posedge clock) disable iff (reset)
		!(ext_arvalid && cl_arvalid));

	a_ifu_hold: assert property (@(posedge clock) disable iff (reset)
		ifu_rvalid && !ifu_rready |=> ifu_rvalid && $stable(ifu_r));

	a_lsu_hold: assert property (@(posedge clock) disable iff (reset)
		lsu_rvalid && !lsu_rready |=> lsu_rvalid && $stable(lsu_r));

endmodule

`default_nettype wire

// ==== clint.sv ====
`timescale 1ns/1ps
`default_nettype none

module clint (
	input  wire                  clock,
	input  wire                  reset,

	input  wire xbar_pkg::addr_t araddr,
	input  wire                  arvalid,
	output logic                 arready,
	output xbar_pkg::word_t      rdata,
	output logic                 rvalid,
	input  wire                  rready
);

	xbar_pkg::word_t mtime;
	logic ar_hs;

	assign ar_hs = arvalid & arready;

	always_ff @(posedge clock) begin
		if (reset) begin
			mtime   <= '0;
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			mtime   <= mtime + 1'b1; // free running
			arready <= arvalid & ~arready & ~rvalid;
			if (ar_hs)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// any offset in the window reads mtime
	always_ff @(posedge clock) begin
		if (ar_hs) rdata <= mtime;
	end

	// only addresses the crossbar decoded as CLINT may land here
	a_in_window: assert property (@(posedge clock) disable iff (reset)
		ar_hs |-> (araddr >= xbar_pkg::CLINT_BASE) && (araddr <= xbar_pkg::CLINT_LAST));

endmodule

`default_nettype wire

// ==== icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache (
	input  wire                  clock,
	input  wire                  reset,

	input  wire xbar_pkg::addr_t araddr,
	input  wire                  arvalid,
	output logic                 arready,
	output xbar_pkg::word_t      rdata,
	output xbar_pkg::resp_t      rresp,
	output logic                 rvalid,
	input  wire                  rready,

	input  wire xbar_pkg::addr_t awaddr,
	input  wire                  awvalid,
	output logic                 awready,
	input  wire xbar_pkg::word_t wdata,
	input  wire                  wvalid,
	output logic                 wready,
	output logic                 bvalid,
	input  wire                  bready
);

	xbar_pkg::word_t lines [xbar_pkg::ICACHE_LINES];
	logic [31:xbar_pkg::ICACHE_IDX_W+2] tags [xbar_pkg::ICACHE_LINES];
	logic [xbar_pkg::ICACHE_LINES-1:0] line_valid;

	xbar_pkg::addr_t rd_addr;
	logic rd_pend; // lookup happens next edge
	logic [xbar_pkg::ICACHE_IDX_W-1:0] rd_idx;
	logic rd_hit;

	xbar_pkg::addr_t fill_addr;
	xbar_pkg::word_t fill_data;
	logic aw_done, w_done;
	logic aw_hs, w_hs, fill_go;
	xbar_pkg::addr_t fill_a;
	xbar_pkg::word_t fill_w;
	logic [xbar_pkg::ICACHE_IDX_W-1:0] fill_idx;

	assign rd_idx = rd_addr[xbar_pkg::ICACHE_IDX_W+1:2];
	assign rd_hit = line_valid[rd_idx] && (tags[rd_idx] == rd_addr[31:xbar_pkg::ICACHE_IDX_W+2]);

	// ****************************************
	// fill port
	// ****************************************

	assign awready = ~aw_done & ~bvalid;
	assign wready  = ~w_done & ~bvalid;
	assign aw_hs   = awvalid & awready;
	assign w_hs    = wvalid & wready;
	assign fill_go = (aw_done | aw_hs) & (w_done | w_hs); // second half just arrived

	assign fill_a   = aw_done ? fill_addr : awaddr;
	assign fill_w   = w_done ? fill_data : wdata;
	assign fill_idx = fill_a[xbar_pkg::ICACHE_IDX_W+1:2];

	always_ff @(posedge clock) begin
		if (reset) begin
			arready    <= 1'b0;
			rd_pend    <= 1'b0;
			rvalid     <= 1'b0;
			aw_done    <= 1'b0;
			w_done     <= 1'b0;
			bvalid     <= 1'b0;
			line_valid <= '0;
		end else begin
			arready <= arvalid & ~arready & ~rd_pend & ~rvalid;
			rd_pend <= arvalid & arready;
			if (rd_pend)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;

			if (fill_go) begin
				aw_done              <= 1'b0;
				w_done               <= 1'b0;
				bvalid               <= 1'b1;
				line_valid[fill_idx] <= 1'b1;
			end else begin
				if (aw_hs) aw_done <= 1'b1;
				if (w_hs) w_done <= 1'b1;
				if (bready) bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (arvalid & arready) rd_addr <= araddr;
		if (rd_pend) begin // response word held until rready
			rdata <= lines[rd_idx];
			rresp <= rd_hit ? xbar_pkg::resp_okay : xbar_pkg::resp_decerr;
		end
		if (aw_hs) fill_addr <= awaddr;
		if (w_hs) fill_data <= wdata;
		if (fill_go) begin
			lines[fill_idx] <= fill_w;
			tags[fill_idx]  <= fill_a[31:xbar_pkg::ICACHE_IDX_W+2];
		end
	end

	// the crossbar only fills after it has taken the lookup result
	a_no_overlap: assert property (@(posedge clock) disable iff (reset)
		!((rd_pend || rvalid) && (aw_done || w_done || bvalid)));

endmodule

`default_nettype wire

// ==== xbar_pkg.sv ====
`default_nettype none

package xbar_pkg;

	// ****************************************
	// vector types
	// ****************************************

	typedef logic [31:0] addr_t; // byte address
	typedef logic [63:0] data_t; // ext / lsu beat
	typedef logic [31:0] word_t; // instruction word, cache entry
	typedef logic [7:0]  strb_t;
	typedef logic [2:0]  size_t; // axi size code
	typedef logic [1:0]  resp_t; // bit 1 set = error or miss

	// ****************************************
	// address map and cache geometry
	// ****************************************

	localparam addr_t CLINT_BASE = 32'h0200_0000;
	localparam addr_t CLINT_LAST = 32'h0200_ffff;

	localparam int ICACHE_LINES = 16;
	localparam int ICACHE_IDX_W = 4; // index is addr[5:2]

	localparam resp_t resp_okay   = 2'b00;
	localparam resp_t resp_decerr = 2'b11; // also the cache miss code

	localparam size_t SIZE_WORD = 3'd2; // fetches and fills

	// ****************************************
	// channel payloads
	// ****************************************

	typedef struct packed {
		addr_t addr;
		size_t size;
	} ar_req_t;

	typedef struct packed {
		data_t data; // requested word in the low half
		resp_t resp;
	} r_rsp_t;

	typedef struct packed {
		addr_t addr;
		size_t size;
	} aw_req_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
	} w_beat_t;

endpackage

`default_nettype wire
